/* gpio_top.f */
+incdir+include
verilog/gpio_pkg.sv
verilog/gpio_event_if.sv
verilog/gpio_bus_adapter.sv
verilog/gpio_reg_file.sv
verilog/gpio_pin_detect.sv
verilog/gpio_top.sv
tb/gpio_asserts.sv
tb/gpio_tb.sv

/* include/gpio_config.svh */
`ifndef GPIO_CONFIG_SVH
`define GPIO_CONFIG_SVH

`define GPIO_WIDTH 32 // Pins
`define GPIO_AW 6 // Byte address into the register map
`define GPIO_DW 32

// Read data returned on an unmapped offset
`define GPIO_MISS_RDATA 32'hffffffff

`endif

/* run.sh */
#!/bin/sh
verilator --binary --assert -f gpio_top.f --top-module gpio_tb -o gpio_sim \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/gpio_sim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
grep -q "Test failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Test passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

/* tb/gpio_asserts.sv */
`timescale 1ns/1ps

`include "gpio_config.svh"

module gpio_asserts import gpio_pkg::*; (
	input logic clk_i,
	input logic rst_i,
	input logic req_valid_i,
	input logic req_write_i,
	input logic [`GPIO_AW-1:0] req_addr_i,
	input logic [`GPIO_DW-1:0] req_wdata_i,
	input logic req_ready_o,
	input logic rsp_valid_o,
	input logic [`GPIO_DW-1:0] rsp_rdata_o,
	input logic rsp_error_o,
	input logic rsp_ready_i,
	input logic [`GPIO_WIDTH-1:0] gpio_o,
	input logic [`GPIO_WIDTH-1:0] gpio_oe_o,
	input logic [`GPIO_WIDTH-1:0] intr_o
);

	logic [`GPIO_WIDTH-1:0] out_sh;
	logic [`GPIO_WIDTH-1:0] oe_sh;
	logic [`GPIO_WIDTH-1:0] en_sh;
	logic [15:0] mask;
	logic wr_acc;

	assign wr_acc = req_valid_i && req_ready_o && req_write_i;
	assign mask = req_wdata_i[31:16];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			out_sh <= '0;
			oe_sh <= '0;
			en_sh <= '0;
		end else if (wr_acc) begin
			case (req_addr_i)
				REG_INTR_ENABLE: en_sh <= req_wdata_i;
				REG_DIRECT_OUT: out_sh <= req_wdata_i;
				REG_DIRECT_OE: oe_sh <= req_wdata_i;
				REG_MASKED_OUT_LOWER: out_sh[15:0] <= (out_sh[15:0] & ~mask) | (req_wdata_i[15:0] & mask);
				REG_MASKED_OUT_UPPER: out_sh[31:16] <= (out_sh[31:16] & ~mask) | (req_wdata_i[15:0] & mask);
				REG_MASKED_OE_LOWER: oe_sh[15:0] <= (oe_sh[15:0] & ~mask) | (req_wdata_i[15:0] & mask);
				REG_MASKED_OE_UPPER: oe_sh[31:16] <= (oe_sh[31:16] & ~mask) | (req_wdata_i[15:0] & mask);
				default: ; // Misses and other registers leave the shadows alone
			endcase
		end
	end

	assert property (@(posedge clk_i) rst_i |=> !rsp_valid_o && req_ready_o
		&& gpio_o == '0 && gpio_oe_o == '0 && intr_o == '0)
		else $error("outputs not idle after reset");
	assert property (@(posedge clk_i) disable iff (rst_i) gpio_o == out_sh && gpio_oe_o == oe_sh)
		else $error("pin outputs differ from accepted writes");
	assert property (@(posedge clk_i) disable iff (rst_i) req_valid_i && req_ready_o |=> rsp_valid_o)
		else $error("no response after an accepted request");
	assert property (@(posedge clk_i) disable iff (rst_i) rsp_valid_o && !rsp_ready_i
		|=> rsp_valid_o && $stable(rsp_rdata_o) && $stable(rsp_error_o))
		else $error("response changed under back-pressure");
	assert property (@(posedge clk_i) disable iff (rst_i) rsp_valid_o && !rsp_ready_i |-> !req_ready_o)
		else $error("request accepted while a response is pending");
	assert property (@(posedge clk_i) disable iff (rst_i) (intr_o & ~en_sh) == '0)
		else $error("interrupt raised on a disabled pin");

endmodule

bind gpio_top gpio_asserts u_asserts (.*);

/* tb/gpio_tb.sv */
`timescale 1ns/1ps

`include "gpio_config.svh"

module gpio_tb import gpio_pkg::*; ();

	logic clk_i;
	logic rst_i;
	logic req_valid_i;
	logic req_write_i;
	logic [`GPIO_AW-1:0] req_addr_i;
	logic [`GPIO_DW-1:0] req_wdata_i;
	logic req_ready_o;
	logic rsp_valid_o;
	logic [`GPIO_DW-1:0] rsp_rdata_o;
	logic rsp_error_o;
	logic rsp_ready_i;
	logic [`GPIO_WIDTH-1:0] gpio_i;
	logic [`GPIO_WIDTH-1:0] gpio_o;
	logic [`GPIO_WIDTH-1:0] gpio_oe_o;
	logic [`GPIO_WIDTH-1:0] intr_o;
	logic [31:0] lcg_state;
	logic [31:0] exp_out;
	logic [31:0] exp_oe;
	logic [31:0] exp_en;
	int mismatches;
	int timeouts;

	gpio_top dut_i (.*);

	always #5 clk_i = ~clk_i;

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Bits 31:16 select which of the data bits 15:0 land
	function automatic logic [15:0] apply_mask(input logic [15:0] old_half, input logic [31:0] data);
		return (old_half & ~data[31:16]) | (data[15:0] & data[31:16]);
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			mismatches++;
			$display("mismatch %s: expected %h, got %h", name, exp, got);
		end
	endtask

	task automatic bus_access(input logic wr, input logic [5:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		logic [31:0] r;
		logic [1:0] hold;
		int t;
		r = next_rand();
		hold = r[1:0]; // Cycles of back-pressure on the response
		t = 0;
		while (!req_ready_o && t < 20) begin
			@(negedge clk_i);
			t++;
		end
		if (!req_ready_o) begin
			timeouts++;
			$display("timeout: the DUT never became ready for a request");
		end
		req_valid_i = 1'b1;
		req_write_i = wr;
		req_addr_i = addr;
		req_wdata_i = wdata;
		rsp_ready_i = (hold == 2'd0);
		@(negedge clk_i);
		req_valid_i = 1'b0;
		t = 0;
		while (!rsp_valid_o && t < 20) begin
			@(negedge clk_i);
			t++;
		end
		if (!rsp_valid_o) begin
			timeouts++;
			$display("timeout: no response arrived for a request");
		end
		rdata = rsp_rdata_o;
		err = rsp_error_o;
		repeat (hold) begin
			check_value("req_ready_o", 32'(req_ready_o), 32'h0);
			@(negedge clk_i);
			check_value("rsp_rdata_o", rsp_rdata_o, rdata);
		end
		rsp_ready_i = 1'b1;
		@(negedge clk_i);
	endtask

	task automatic write_reg(input logic [5:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic er;
		bus_access(1'b1, addr, data, rd, er);
		check_value("rsp_error_o", 32'(er), 32'h0);
		case (addr)
			REG_INTR_ENABLE: exp_en = data;
			REG_DIRECT_OUT: exp_out = data;
			REG_MASKED_OUT_LOWER: exp_out[15:0] = apply_mask(exp_out[15:0], data);
			REG_MASKED_OUT_UPPER: exp_out[31:16] = apply_mask(exp_out[31:16], data);
			REG_DIRECT_OE: exp_oe = data;
			REG_MASKED_OE_LOWER: exp_oe[15:0] = apply_mask(exp_oe[15:0], data);
			REG_MASKED_OE_UPPER: exp_oe[31:16] = apply_mask(exp_oe[31:16], data);
			default: ;
		endcase
		check_value("gpio_o", gpio_o, exp_out);
		check_value("gpio_oe_o", gpio_oe_o, exp_oe);
	endtask

	task automatic read_check(input logic [5:0] addr, input logic [31:0] exp);
		logic [31:0] rd;
		logic er;
		bus_access(1'b0, addr, 32'h0, rd, er);
		check_value("rsp_error_o", 32'(er), 32'h0);
		check_value("rsp_rdata_o", rd, exp);
	endtask

	initial begin
		logic [31:0] d;
		logic [31:0] c;
		logic [31:0] rd;
		logic er;
		clk_i = 1'b0;
		rst_i = 1'b1;
		req_valid_i = 1'b0;
		req_write_i = 1'b0;
		req_addr_i = '0;
		req_wdata_i = '0;
		rsp_ready_i = 1'b1;
		gpio_i = '0;
		lcg_state = 32'h1a9e;
		exp_out = '0;
		exp_oe = '0;
		exp_en = '0;
		mismatches = 0;
		timeouts = 0;
		repeat (4) begin
			@(negedge clk_i);
			check_value("rsp_valid_o", 32'(rsp_valid_o), 32'h0);
			check_value("req_ready_o", 32'(req_ready_o), 32'h1);
			check_value("gpio_o", gpio_o, 32'h0);
			check_value("gpio_oe_o", gpio_oe_o, 32'h0);
			check_value("intr_o", intr_o, 32'h0);
		end
		rst_i = 1'b0;
		d = next_rand();
		write_reg(REG_DIRECT_OUT, d);
		read_check(REG_DIRECT_OUT, d);
		d = next_rand();
		write_reg(REG_DIRECT_OE, d);
		read_check(REG_DIRECT_OE, d);
		repeat (2) begin
			write_reg(REG_MASKED_OUT_LOWER, next_rand());
			write_reg(REG_MASKED_OUT_UPPER, next_rand());
			write_reg(REG_MASKED_OE_LOWER, next_rand());
			write_reg(REG_MASKED_OE_UPPER, next_rand());
		end
		read_check(REG_MASKED_OUT_UPPER, {16'h0000, exp_out[31:16]});
		read_check(REG_DIRECT_OE, exp_oe);
		bus_access(1'b0, 6'h3c, 32'h0, rd, er); // Unmapped offset
		check_value("rsp_error_o", 32'(er), 32'h1);
		check_value("rsp_rdata_o", rd, `GPIO_MISS_RDATA);
		bus_access(1'b1, 6'h3c, next_rand(), rd, er);
		check_value("rsp_error_o", 32'(er), 32'h1);
		check_value("gpio_o", gpio_o, exp_out);
		check_value("gpio_oe_o", gpio_oe_o, exp_oe);
		write_reg(REG_INTR_ENABLE, next_rand());
		write_reg(REG_INTR_TEST, 32'hffffffff);
		write_reg(REG_INTR_STATE, 32'hffffffff);
		check_value("intr_o", intr_o, 32'h0);
		d = next_rand();
		write_reg(REG_INTR_TEST, d);
		check_value("intr_o", intr_o, d & exp_en);
		read_check(REG_INTR_STATE, d);
		c = next_rand();
		write_reg(REG_INTR_STATE, c); // Clears only the bits written as 1
		check_value("intr_o", intr_o, d & ~c & exp_en);
		read_check(REG_INTR_STATE, d & ~c);
		write_reg(REG_INTR_ENABLE, 32'hffffffff);
		write_reg(REG_INTR_STATE, 32'hffffffff);
		write_reg(REG_INTR_CTRL_EN_RISING, 32'h00000020);
		gpio_i[5] = 1'b1; // Two flops to sync, one more into the state
		repeat (2) @(negedge clk_i);
		check_value("intr_o[5]", 32'(intr_o[5]), 32'h0);
		@(negedge clk_i);
		check_value("intr_o[5]", 32'(intr_o[5]), 32'h1);
		gpio_i[9] = 1'b1;
		repeat (2) @(negedge clk_i);
		read_check(REG_DATA_IN, 32'h00000220);
		write_reg(REG_INTR_CTRL_EN_LVLLOW, 32'h00000008);
		write_reg(REG_INTR_STATE, 32'h00000008);
		read_check(REG_INTR_STATE, 32'h00000028);
		check_value("intr_o", intr_o, 32'h00000028);
		gpio_i[3] = 1'b1;
		repeat (3) @(negedge clk_i);
		write_reg(REG_INTR_STATE, 32'hffffffff);
		read_check(REG_INTR_STATE, 32'h0);
		$display("mismatches %0d, timeouts %0d", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* verilog/gpio_bus_adapter.sv */
`timescale 1ns/1ps

`include "gpio_config.svh"

module gpio_bus_adapter import gpio_pkg::*; (
	input logic clk_i,
	input logic rst_i,
	input logic req_valid_i,
	input logic req_write_i,
	input logic [`GPIO_AW-1:0] req_addr_i,
	input logic [`GPIO_DW-1:0] req_wdata_i,
	output logic req_ready_o,
	output logic rsp_valid_o,
	output logic [`GPIO_DW-1:0] rsp_rdata_o,
	output logic rsp_error_o,
	input logic rsp_ready_i,
	output logic acc_valid_o,
	output bus_op_e acc_op_o,
	output logic [`GPIO_AW-1:0] acc_addr_o,
	output logic [`GPIO_DW-1:0] acc_wdata_o,
	input logic [`GPIO_DW-1:0] acc_rdata_i,
	input logic acc_error_i
);

	logic rsp_valid_q;
	logic [`GPIO_DW-1:0] rsp_rdata_q;
	logic rsp_error_q;

	// Accept when no response is pending, or the pending one leaves now
	assign req_ready_o = !rsp_valid_q || rsp_ready_i;
	assign acc_valid_o = req_valid_i && req_ready_o;
	assign acc_op_o = req_write_i ? OP_WRITE : OP_READ;
	assign acc_addr_o = req_addr_i;
	assign acc_wdata_o = req_wdata_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rsp_valid_q <= 1'b0;
		end else if (acc_valid_o) begin
			rsp_valid_q <= 1'b1;
		end else if (rsp_ready_i) begin
			rsp_valid_q <= 1'b0; // Response taken
		end
	end

	always_ff @(posedge clk_i) begin
		if (acc_valid_o) begin
			rsp_rdata_q <= acc_rdata_i; // Held until the host takes it
			rsp_error_q <= acc_error_i;
		end
	end

	assign rsp_valid_o = rsp_valid_q;
	assign rsp_rdata_o = rsp_rdata_q;
	assign rsp_error_o = rsp_error_q;

endmodule

/* verilog/gpio_event_if.sv */
`timescale 1ns/1ps

`include "gpio_config.svh"

interface gpio_event_if;

	logic [`GPIO_WIDTH-1:0] rise_en;
	logic [`GPIO_WIDTH-1:0] fall_en;
	logic [`GPIO_WIDTH-1:0] high_en;
	logic [`GPIO_WIDTH-1:0] low_en;
	logic [`GPIO_WIDTH-1:0] data_in; // Synchronized pin values
	logic [`GPIO_WIDTH-1:0] pin_event; // Pulse on edge, held while level lasts

	modport reg_side (
		output rise_en, fall_en, high_en, low_en,
		input data_in, pin_event
	);

	modport detect_side (
		input rise_en, fall_en, high_en, low_en,
		output data_in, pin_event
	);

endinterface

/* verilog/gpio_pin_detect.sv */
`timescale 1ns/1ps

`include "gpio_config.svh"

module gpio_pin_detect (
	input logic clk_i,
	input logic rst_i,
	input logic [`GPIO_WIDTH-1:0] gpio_i,
	gpio_event_if.detect_side ev
);

	logic [`GPIO_WIDTH-1:0] sync_q; // First stage, may go metastable
	logic [`GPIO_WIDTH-1:0] data_q;
	logic [`GPIO_WIDTH-1:0] prev_q;
	logic [`GPIO_WIDTH-1:0] rising;
	logic [`GPIO_WIDTH-1:0] falling;
	logic [`GPIO_WIDTH-1:0] level_high;
	logic [`GPIO_WIDTH-1:0] level_low;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			sync_q <= '0;
			data_q <= '0;
			prev_q <= '0;
		end else begin
			sync_q <= gpio_i;
			data_q <= sync_q;
			prev_q <= data_q; // For edge compare
		end
	end

	assign rising = data_q & ~prev_q;
	assign falling = ~data_q & prev_q;
	assign level_high = data_q;
	assign level_low = ~data_q;

	// Per pin OR of the enabled conditions
	assign ev.pin_event = (rising & ev.rise_en)
		| (falling & ev.fall_en)
		| (level_high & ev.high_en)
		| (level_low & ev.low_en);

	assign ev.data_in = data_q;

endmodule

/* verilog/gpio_pkg.sv */
`include "gpio_config.svh"

package gpio_pkg;

	typedef enum logic [`GPIO_AW-1:0] {
		REG_INTR_STATE = 6'h00, // W1C
		REG_INTR_ENABLE = 6'h04,
		REG_INTR_TEST = 6'h08, // Write only, reads zero
		REG_DATA_IN = 6'h0c, // Read only
		REG_DIRECT_OUT = 6'h10,
		REG_MASKED_OUT_LOWER = 6'h14,
		REG_MASKED_OUT_UPPER = 6'h18,
		REG_DIRECT_OE = 6'h1c,
		REG_MASKED_OE_LOWER = 6'h20,
		REG_MASKED_OE_UPPER = 6'h24,
		REG_INTR_CTRL_EN_RISING = 6'h28,
		REG_INTR_CTRL_EN_FALLING = 6'h2c,
		REG_INTR_CTRL_EN_LVLHIGH = 6'h30,
		REG_INTR_CTRL_EN_LVLLOW = 6'h34
	} gpio_reg_e;

	typedef enum logic {
		OP_READ = 1'b0,
		OP_WRITE = 1'b1
	} bus_op_e;

endpackage

/* verilog/gpio_reg_file.sv */
`timescale 1ns/1ps

`include "gpio_config.svh"

module gpio_reg_file import gpio_pkg::*; (
	input logic clk_i,
	input logic rst_i,
	input logic acc_valid_i,
	input bus_op_e acc_op_i,
	input logic [`GPIO_AW-1:0] acc_addr_i,
	input logic [`GPIO_DW-1:0] acc_wdata_i,
	output logic [`GPIO_DW-1:0] acc_rdata_o,
	output logic acc_error_o,
	output logic [`GPIO_WIDTH-1:0] gpio_o,
	output logic [`GPIO_WIDTH-1:0] gpio_oe_o,
	output logic [`GPIO_WIDTH-1:0] intr_o,
	gpio_event_if.reg_side ev
);

	logic [`GPIO_WIDTH-1:0] intr_state_q;
	logic [`GPIO_WIDTH-1:0] intr_enable_q;
	logic [`GPIO_WIDTH-1:0] out_q;
	logic [`GPIO_WIDTH-1:0] oe_q;
	logic [`GPIO_WIDTH-1:0] rise_en_q;
	logic [`GPIO_WIDTH-1:0] fall_en_q;
	logic [`GPIO_WIDTH-1:0] high_en_q;
	logic [`GPIO_WIDTH-1:0] low_en_q;
	logic [`GPIO_WIDTH-1:0] intr_state_d;
	logic [`GPIO_WIDTH-1:0] w1c_bits;
	logic [`GPIO_WIDTH-1:0] test_bits;
	logic miss;
	logic wr_en;

	// Data in 15:0 lands where mask bit in 31:16 is set
	function automatic logic [15:0] masked_merge(
		input logic [15:0] old_val,
		input logic [`GPIO_DW-1:0] wdata
	);
		logic [15:0] mask;
		mask = wdata[31:16];
		return (old_val & ~mask) | (wdata[15:0] & mask);
	endfunction

	// Readback mux and decode
	always_comb begin
		acc_rdata_o = '0;
		miss = 1'b0;
		case (acc_addr_i)
			REG_INTR_STATE: acc_rdata_o = intr_state_q;
			REG_INTR_ENABLE: acc_rdata_o = intr_enable_q;
			REG_INTR_TEST: acc_rdata_o = '0;
			REG_DATA_IN: acc_rdata_o = ev.data_in;
			REG_DIRECT_OUT: acc_rdata_o = out_q;
			REG_MASKED_OUT_LOWER: acc_rdata_o = {16'h0000, out_q[15:0]};
			REG_MASKED_OUT_UPPER: acc_rdata_o = {16'h0000, out_q[31:16]};
			REG_DIRECT_OE: acc_rdata_o = oe_q;
			REG_MASKED_OE_LOWER: acc_rdata_o = {16'h0000, oe_q[15:0]};
			REG_MASKED_OE_UPPER: acc_rdata_o = {16'h0000, oe_q[31:16]};
			REG_INTR_CTRL_EN_RISING: acc_rdata_o = rise_en_q;
			REG_INTR_CTRL_EN_FALLING: acc_rdata_o = fall_en_q;
			REG_INTR_CTRL_EN_LVLHIGH: acc_rdata_o = high_en_q;
			REG_INTR_CTRL_EN_LVLLOW: acc_rdata_o = low_en_q;
			default: begin
				acc_rdata_o = `GPIO_MISS_RDATA;
				miss = 1'b1;
			end
		endcase
	end

	assign acc_error_o = miss;
	assign wr_en = acc_valid_i && (acc_op_i == OP_WRITE) && !miss;

	assign w1c_bits = (wr_en && acc_addr_i == REG_INTR_STATE) ? acc_wdata_i : '0;
	assign test_bits = (wr_en && acc_addr_i == REG_INTR_TEST) ? acc_wdata_i : '0;
	assign intr_state_d = (intr_state_q & ~w1c_bits) | ev.pin_event | test_bits; // Set wins

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			intr_state_q <= '0;
			intr_enable_q <= '0;
			out_q <= '0;
			oe_q <= '0;
			rise_en_q <= '0;
			fall_en_q <= '0;
			high_en_q <= '0;
			low_en_q <= '0;
		end else begin
			intr_state_q <= intr_state_d;
			if (wr_en) begin
				case (acc_addr_i)
					REG_INTR_ENABLE: intr_enable_q <= acc_wdata_i;
					REG_DIRECT_OUT: out_q <= acc_wdata_i;
					REG_MASKED_OUT_LOWER: out_q[15:0] <= masked_merge(out_q[15:0], acc_wdata_i);
					REG_MASKED_OUT_UPPER: out_q[31:16] <= masked_merge(out_q[31:16], acc_wdata_i);
					REG_DIRECT_OE: oe_q <= acc_wdata_i;
					REG_MASKED_OE_LOWER: oe_q[15:0] <= masked_merge(oe_q[15:0], acc_wdata_i);
					REG_MASKED_OE_UPPER: oe_q[31:16] <= masked_merge(oe_q[31:16], acc_wdata_i);
					REG_INTR_CTRL_EN_RISING: rise_en_q <= acc_wdata_i;
					REG_INTR_CTRL_EN_FALLING: fall_en_q <= acc_wdata_i;
					REG_INTR_CTRL_EN_LVLHIGH: high_en_q <= acc_wdata_i;
					REG_INTR_CTRL_EN_LVLLOW: low_en_q <= acc_wdata_i;
					default: ; // State, test and data_in handled elsewhere
				endcase
			end
		end
	end

	assign gpio_o = out_q;
	assign gpio_oe_o = oe_q;
	assign intr_o = intr_state_q & intr_enable_q;

	assign ev.rise_en = rise_en_q;
	assign ev.fall_en = fall_en_q;
	assign ev.high_en = high_en_q;
	assign ev.low_en = low_en_q;

endmodule

/* verilog/gpio_top.sv */
`timescale 1ns/1ps

`include "gpio_config.svh"

module gpio_top import gpio_pkg::*; (
	input logic clk_i,
	input logic rst_i,
	input logic req_valid_i,
	input logic req_write_i,
	input logic [`GPIO_AW-1:0] req_addr_i,
	input logic [`GPIO_DW-1:0] req_wdata_i,
	output logic req_ready_o,
	output logic rsp_valid_o,
	output logic [`GPIO_DW-1:0] rsp_rdata_o,
	output logic rsp_error_o,
	input logic rsp_ready_i,
	input logic [`GPIO_WIDTH-1:0] gpio_i,
	output logic [`GPIO_WIDTH-1:0] gpio_o,
	output logic [`GPIO_WIDTH-1:0] gpio_oe_o,
	output logic [`GPIO_WIDTH-1:0] intr_o
);

	logic acc_valid;
	bus_op_e acc_op;
	logic [`GPIO_AW-1:0] acc_addr;
	logic [`GPIO_DW-1:0] acc_wdata;
	logic [`GPIO_DW-1:0] acc_rdata;
	logic acc_error;

	gpio_event_if ev_if ();

	gpio_bus_adapter u_bus_adapter (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.req_valid_i(req_valid_i),
		.req_write_i(req_write_i),
		.req_addr_i(req_addr_i),
		.req_wdata_i(req_wdata_i),
		.req_ready_o(req_ready_o),
		.rsp_valid_o(rsp_valid_o),
		.rsp_rdata_o(rsp_rdata_o),
		.rsp_error_o(rsp_error_o),
		.rsp_ready_i(rsp_ready_i),
		.acc_valid_o(acc_valid),
		.acc_op_o(acc_op),
		.acc_addr_o(acc_addr),
		.acc_wdata_o(acc_wdata),
		.acc_rdata_i(acc_rdata),
		.acc_error_i(acc_error)
	);

	gpio_reg_file u_reg_file (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.acc_valid_i(acc_valid),
		.acc_op_i(acc_op),
		.acc_addr_i(acc_addr),
		.acc_wdata_i(acc_wdata),
		.acc_rdata_o(acc_rdata),
		.acc_error_o(acc_error),
		.gpio_o(gpio_o),
		.gpio_oe_o(gpio_oe_o),
		.intr_o(intr_o),
		.ev(ev_if.reg_side)
	);

	gpio_pin_detect u_pin_detect (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.gpio_i(gpio_i),
		.ev(ev_if.detect_side)
	);

endmodule
